/* design/mvu_dims_pkg.sv */
`default_nettype none

package mvu_dims_pkg;

    // Engine geometry

    // Output rows computed in parallel
    localparam int unsigned PE_COUNT = 4;

    // Multipliers per PE, one per activation element
    localparam int unsigned SIMD_COUNT = 4;

    // Element widths

    // One activation element, signed or unsigned per core setting
    localparam int unsigned ACT_WIDTH = 4;

    // One weight, always signed
    localparam int unsigned WGT_WIDTH = 4;

    // Per-PE accumulator, wraps on overflow
    localparam int unsigned ACC_WIDTH = 16;

    // Top-level defaults

    // Beats per dot product
    localparam int unsigned SF_DEFAULT = 3;

    // Result FIFO slots
    localparam int unsigned OUT_DEPTH_DEFAULT = 4;

endpackage : mvu_dims_pkg

`default_nettype wire

/* design/mvu_input_join.sv */
`timescale 1ns/1ps
`default_nettype none

module mvu_input_join #(
    parameter int unsigned SF = mvu_dims_pkg::SF_DEFAULT
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     en,

    // Activation stream
    input  wire logic                     act_valid,
    output logic                          act_ready,
    input  wire mvu_stream_pkg::act_beat_t act_data,

    // Weight stream
    input  wire logic                     wgt_valid,
    output logic                          wgt_ready,
    input  wire mvu_stream_pkg::wgt_beat_t wgt_data,

    // Core side
    output logic                          last,
    output logic                          zero,
    output mvu_stream_pkg::act_beat_t     a,
    output mvu_stream_pkg::wgt_beat_t     w
);

    localparam int unsigned CNT_WIDTH = (SF > 1) ? $clog2(SF) : 1;

    logic                 pair_avail;
    logic                 fire;
    logic                 final_beat;
    logic [CNT_WIDTH-1:0] beat_cnt;

    // Both halves of a beat present
    assign pair_avail = act_valid && wgt_valid;

    // A beat is consumed only when the core can advance
    assign fire = pair_avail && en;

    // Each ready waits on the other stream so that neither side
    // is taken without its partner
    assign act_ready = en && wgt_valid;
    assign wgt_ready = en && act_valid;

    assign final_beat = (beat_cnt == CNT_WIDTH'(SF - 1));

    // Data passes straight to the core and zero masks it on a bubble
    assign a    = act_data;
    assign w    = wgt_data;
    assign zero = !pair_avail;
    assign last = pair_avail && final_beat;

    // Position of the next beat within the current dot product
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (fire) begin
            if (final_beat) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // A bubble never closes a dot product
    a_last_not_bubble : assert property (
        @(posedge clk) disable iff (rst)
        !(last && zero)
    );

    // Counter wraps at SF
    a_cnt_range : assert property (
        @(posedge clk) disable iff (rst)
        32'(beat_cnt) < SF
    );

endmodule : mvu_input_join

`default_nettype wire

/* design/mvu_lut_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mvu_lut_top #(
    parameter int unsigned SF                 = mvu_dims_pkg::SF_DEFAULT,
    parameter bit          SIGNED_ACTIVATIONS = 1,
    parameter int unsigned M_REG              = 1,
    parameter int unsigned OUT_DEPTH          = mvu_dims_pkg::OUT_DEPTH_DEFAULT
) (
    input  wire logic                      clk,
    input  wire logic                      rst,

    // Activation stream
    input  wire logic                      act_valid,
    output logic                           act_ready,
    input  wire mvu_stream_pkg::act_beat_t act_data,

    // Weight stream
    input  wire logic                      wgt_valid,
    output logic                           wgt_ready,
    input  wire mvu_stream_pkg::wgt_beat_t wgt_data,

    // Result stream
    output logic                           res_valid,
    input  wire logic                      res_ready,
    output mvu_stream_pkg::result_t        res_data
);

    import mvu_stream_pkg::*;

    // Pipeline advance, driven by the FIFO
    logic      en;

    // Joined beat into the core
    logic      last;
    logic      zero;
    act_beat_t a;
    wgt_beat_t w;

    // Finished dot product from the core
    logic      vld;
    result_t   p;

    mvu_input_join #(
        .SF         (SF)
    ) i_join (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .act_valid  (act_valid),
        .act_ready  (act_ready),
        .act_data   (act_data),
        .wgt_valid  (wgt_valid),
        .wgt_ready  (wgt_ready),
        .wgt_data   (wgt_data),
        .last       (last),
        .zero       (zero),
        .a          (a),
        .w          (w)
    );

    // One activation vector shared by all PE rows
    mvu_vvu_lut #(
        .IS_MVU             (1'b1),
        .SIGNED_ACTIVATIONS (SIGNED_ACTIVATIONS),
        .M_REG              (M_REG)
    ) i_core (
        .clk                (clk),
        .rst                (rst),
        .en                 (en),
        .last               (last),
        .zero               (zero),
        .w                  (w),
        .a                  (a),
        .vld                (vld),
        .p                  (p)
    );

    mvu_result_fifo #(
        .OUT_DEPTH  (OUT_DEPTH)
    ) i_fifo (
        .clk        (clk),
        .rst        (rst),
        .vld        (vld),
        .p          (p),
        .en         (en),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_data   (res_data)
    );

endmodule : mvu_lut_top

`default_nettype wire

/* design/mvu_result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module mvu_result_fifo #(
    parameter int unsigned OUT_DEPTH = mvu_dims_pkg::OUT_DEPTH_DEFAULT
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // Core side
    input  wire logic                    vld,
    input  wire mvu_stream_pkg::result_t p,
    output logic                         en,

    // Result stream
    output logic                         res_valid,
    input  wire logic                    res_ready,
    output mvu_stream_pkg::result_t      res_data
);

    import mvu_stream_pkg::*;

    localparam int unsigned PTR_WIDTH   = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int unsigned COUNT_WIDTH = $clog2(OUT_DEPTH + 1);

    result_t                mem [OUT_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   wr_en;
    logic                   rd_en;

    // Free slot keeps the whole pipeline moving
    assign en        = (count != COUNT_WIDTH'(OUT_DEPTH));
    assign res_valid = (count != '0);
    assign res_data  = mem[rd_ptr];

    assign wr_en = en && vld;
    assign rd_en = res_valid && res_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= p;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A result offered by the core while full would be lost
    a_no_write_full : assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (count < COUNT_WIDTH'(OUT_DEPTH))
    );

    a_count_range : assert property (
        @(posedge clk) disable iff (rst)
        count <= COUNT_WIDTH'(OUT_DEPTH)
    );

    // Head entry stays put until the consumer takes it
    a_head_stable : assert property (
        @(posedge clk) disable iff (rst)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_data))
    );

endmodule : mvu_result_fifo

`default_nettype wire

/* design/mvu_stream_pkg.sv */
`default_nettype none

package mvu_stream_pkg;

    import mvu_dims_pkg::*;

    // One activation vector, shared by all PE rows
    typedef struct packed {
        logic [SIMD_COUNT-1:0][ACT_WIDTH-1:0] elem;
    } act_beat_t;

    // One weight tile, indexed as wgt[pe][simd]
    typedef struct packed {
        logic signed [PE_COUNT-1:0][SIMD_COUNT-1:0][WGT_WIDTH-1:0] wgt;
    } wgt_beat_t;

    // Finished dot products, one accumulator per PE
    // Used both by the core output and by the result stream
    typedef struct packed {
        logic signed [PE_COUNT-1:0][ACC_WIDTH-1:0] acc;
    } result_t;

endpackage : mvu_stream_pkg

`default_nettype wire

/* design/mvu_vvu_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module mvu_vvu_lut #(
    parameter bit          IS_MVU             = 1,
    parameter bit          SIGNED_ACTIVATIONS = 1,
    parameter int unsigned M_REG              = 1
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      en,

    input  wire logic                      last,
    // Forces this beat's products to zero
    input  wire logic                      zero,
    input  wire mvu_stream_pkg::wgt_beat_t w,
    input  wire mvu_stream_pkg::act_beat_t a,

    output logic                           vld,
    output mvu_stream_pkg::result_t        p
);

    import mvu_dims_pkg::*;

    localparam int unsigned MULT_WIDTH = ACT_WIDTH + WGT_WIDTH;
    localparam int unsigned ROOT_WIDTH = MULT_WIDTH + $clog2(SIMD_COUNT);

    // Number of leaves below a node of the heap-ordered adder tree
    function automatic int unsigned leaf_load(int unsigned node);
        int unsigned load [2*SIMD_COUNT-1];
        for (int k = 2*SIMD_COUNT-2; k >= 0; k--) begin
            if (k >= int'(SIMD_COUNT) - 1) begin
                load[k] = 1;
            end else begin
                load[k] = load[2*k+1] + load[2*k+2];
            end
        end
        return load[node];
    endfunction

    // Activation is sign- or zero-extended by one bit, weight is signed
    function automatic logic signed [MULT_WIDTH-1:0] mul(
        logic [ACT_WIDTH-1:0] av,
        logic [WGT_WIDTH-1:0] wv
    );
        logic signed [ACT_WIDTH:0]     ax;
        logic signed [MULT_WIDTH-1:0] prod;
        ax   = SIGNED_ACTIVATIONS ? {av[ACT_WIDTH-1], av} : {1'b0, av};
        prod = ax * $signed(wv);
        return prod;
    endfunction

    // Only the shared-activation layout fits the activation stream
    if (!IS_MVU) begin : g_mode_check
        $error("mvu_vvu_lut: only MVU mode is supported by act_beat_t");
    end

    // Last flag follows the product and accumulate stages
    logic [M_REG:0] last_pipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_pipe <= '0;
        end else if (en) begin
            last_pipe[0] <= last;
            for (int k = 1; k <= int'(M_REG); k++) begin
                last_pipe[k] <= last_pipe[k-1];
            end
        end
    end

    assign vld = last_pipe[M_REG];

    for (genvar i = 0; i < PE_COUNT; i++) begin : g_pe
        logic signed [MULT_WIDTH-1:0] prod [SIMD_COUNT];
        logic signed [ROOT_WIDTH-1:0] tree [2*SIMD_COUNT-1];
        logic signed [ACC_WIDTH-1:0]  acc;

        // Stage 1, SIMD products
        if (M_REG != 0) begin : g_mreg
            logic signed [MULT_WIDTH-1:0] prod_q [SIMD_COUNT];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int j = 0; j < int'(SIMD_COUNT); j++) begin
                        prod_q[j] <= '0;
                    end
                end else if (en) begin
                    for (int j = 0; j < int'(SIMD_COUNT); j++) begin
                        prod_q[j] <= zero ? '0 : mul(a.elem[j], w.wgt[i][j]);
                    end
                end
            end

            assign prod = prod_q;
        end else begin : g_no_mreg
            always_comb begin
                for (int j = 0; j < int'(SIMD_COUNT); j++) begin
                    prod[j] = zero ? '0 : mul(a.elem[j], w.wgt[i][j]);
                end
            end
        end

        // Stage 2, adder tree with leaves at the top of the heap
        for (genvar s = 0; s < SIMD_COUNT; s++) begin : g_leaf
            assign tree[SIMD_COUNT-1+s] = ROOT_WIDTH'(prod[s]);
        end

        for (genvar n = 0; n < SIMD_COUNT-1; n++) begin : g_node
            // Node trimmed to the range its leaves can reach
            localparam int unsigned NODE_WIDTH = MULT_WIDTH + $clog2(leaf_load(n));
            logic signed [NODE_WIDTH-1:0] node_sum;

            assign node_sum = NODE_WIDTH'(tree[2*n+1] + tree[2*n+2]);
            assign tree[n]  = ROOT_WIDTH'(node_sum);
        end

        // Stage 3, accumulate, restart after a delivered result
        always_ff @(posedge clk) begin
            if (rst) begin
                acc <= '0;
            end else if (en) begin
                if (vld) begin
                    acc <= ACC_WIDTH'(tree[0]);
                end else begin
                    acc <= acc + ACC_WIDTH'(tree[0]);
                end
            end
        end

        assign p.acc[i] = acc;
    end

    // Pipeline is frozen while en is low
    a_vld_frozen : assert property (
        @(posedge clk) disable iff (rst)
        !en |=> $stable(vld)
    );

endmodule : mvu_vvu_lut

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the MVU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mvu_lut \
    -f sources.f \
    -o sim_tb_mvu_lut

status=0
out=$(./obj_dir/sim_tb_mvu_lut 2>&1) || status=$?
echo "$out"

if grep -q "^Regression passed$" <<< "$out"; then
    exit 0
fi
echo "Simulation did not pass, exit status ${status}"
exit 1

/* sources.f */
+incdir+tests
design/mvu_dims_pkg.sv
design/mvu_stream_pkg.sv
design/mvu_input_join.sv
design/mvu_vvu_lut.sv
design/mvu_result_fifo.sv
design/mvu_lut_top.sv
tests/tb_mvu_lut.sv

/* tests/tb_mvu_lut_tasks.svh */
`ifndef TB_MVU_LUT_TASKS_SVH
`define TB_MVU_LUT_TASKS_SVH

task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
        tests_passed++;
        $display("%s: passed", name);
    end else begin
        tests_failed++;
        $display("%s: failed", name);
    end
endtask

// Offer queued beats, each valid rising with chance 100 - gap_pct
// Both streams rest for pause cycles after every joined beat
task automatic drive_streams(input int gap_pct, input int pause);
    logic av_on;
    logic wv_on;
    logic act_took;
    logic wgt_took;
    int   idle;
    av_on = 1'b0;
    wv_on = 1'b0;
    idle  = 0;
    while (act_q.size() > 0 && idle < WAIT_LIMIT) begin
        if (!av_on && $urandom_range(99) >= gap_pct) begin
            av_on = 1'b1;
        end
        if (!wv_on && $urandom_range(99) >= gap_pct) begin
            wv_on = 1'b1;
        end
        act_valid <= av_on;
        act_data  <= act_q[0];
        wgt_valid <= wv_on;
        wgt_data  <= wgt_q[0];
        @(posedge clk);
        act_took = av_on && act_ready;
        wgt_took = wv_on && wgt_ready;
        assert (act_took == wgt_took) else begin
            $display("Activation and weight beats were taken in different cycles");
            err_count++;
        end
        if (act_took || wgt_took) begin
            void'(act_q.pop_front());
            void'(wgt_q.pop_front());
            av_on = 1'b0;
            wv_on = 1'b0;
            idle  = 0;
            if (pause > 0) begin
                act_valid <= 1'b0;
                wgt_valid <= 1'b0;
                repeat (pause) @(posedge clk);
            end
        end else begin
            idle++;
        end
    end
    act_valid <= 1'b0;
    wgt_valid <= 1'b0;
    if (act_q.size() > 0) begin
        $display("Timed out offering input beats, %0d left", act_q.size());
        err_count++;
        act_q.delete();
        wgt_q.delete();
    end
endtask

// Wait for all expected results, then make sure nothing extra follows
task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < WAIT_LIMIT) begin
        @(posedge clk);
        cycles++;
    end
    assert (exp_q.size() == 0) else begin
        $display("Timed out with %0d results still missing", exp_q.size());
        err_count++;
        exp_q.delete();
    end
    repeat (8) @(posedge clk);
    assert (!res_valid) else begin
        $display("An extra result is left in the output FIFO");
        err_count++;
    end
endtask

task automatic test_reset();
    int errs;
    errs = err_count;
    rst <= 1'b1;
    for (int c = 0; c < 10; c++) begin
        @(posedge clk);
        if (c > 0) begin
            check_flag("res_valid", 1'b0, res_valid);
        end
    end
    rst       <= 1'b0;
    act_valid <= 1'b1;
    @(posedge clk);
    // Each ready needs the partner valid, so one side at a time
    check_flag("wgt_ready", 1'b1, wgt_ready);
    check_flag("res_valid", 1'b0, res_valid);
    act_valid <= 1'b0;
    wgt_valid <= 1'b1;
    @(posedge clk);
    check_flag("act_ready", 1'b1, act_ready);
    wgt_valid <= 1'b0;
    @(posedge clk);
    finish_test("reset state", errs);
endtask

task automatic test_known_values();
    int errs;
    errs = err_count;
    // -8 * -8 everywhere
    act_q.push_back(16'h8888);
    wgt_q.push_back(64'h8888_8888_8888_8888);
    // 7 against -8, 7, -1, 0 per PE
    act_q.push_back(16'h7777);
    wgt_q.push_back(64'h0000_FFFF_7777_8888);
    // Elements 7, -8, 1, -1 against weight 1
    act_q.push_back(16'hF187);
    wgt_q.push_back(64'h1111_1111_1111_1111);
    // PE3 to PE0 are 255, 227, 451, 31
    exp_q.push_back(64'h00FF_00E3_01C3_001F);
    drive_streams(0, 0);
    wait_drain();
    finish_test("known values", errs);
endtask

task automatic test_back_to_back();
    int errs;
    errs = err_count;
    repeat (20) random_dot();
    drive_streams(0, 0);
    wait_drain();
    finish_test("back to back", errs);
endtask

task automatic test_misaligned();
    int errs;
    errs = err_count;
    repeat (10) random_dot();
    drive_streams(50, 0);
    wait_drain();
    finish_test("misaligned streams", errs);
endtask

// Hold results until the join stalls, then drain in a random pattern
task automatic release_results();
    int cycles;
    cycles = 0;
    do begin
        @(posedge clk);
        cycles++;
    end while (!(act_valid && !act_ready) && cycles < WAIT_LIMIT);
    assert (cycles < WAIT_LIMIT) else begin
        $display("Input readies never fell while results were held");
        err_count++;
    end
    repeat (4) begin
        @(posedge clk);
        check_flag("act_ready", 1'b0, act_ready);
        check_flag("wgt_ready", 1'b0, wgt_ready);
    end
    cycles = 0;
    while (exp_q.size() > 0 && cycles < WAIT_LIMIT) begin
        res_ready <= ($urandom_range(99) < 60);
        @(posedge clk);
        cycles++;
    end
    res_ready <= 1'b1;
endtask

task automatic test_back_pressure();
    int errs;
    errs = err_count;
    repeat (8) random_dot();
    res_ready <= 1'b0;
    fork
        drive_streams(0, 0);
        release_results();
    join
    wait_drain();
    finish_test("back pressure", errs);
endtask

task automatic test_idle_gaps();
    int errs;
    errs = err_count;
    repeat (4) random_dot();
    drive_streams(0, 5);
    wait_drain();
    finish_test("idle gaps", errs);
endtask

`endif

/* tests/tb_mvu_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mvu_lut;

    import mvu_dims_pkg::*;
    import mvu_stream_pkg::*;

    localparam int unsigned SF         = 3;
    localparam int          WAIT_LIMIT = 200;
    localparam int          ACT_BITS   = $bits(act_beat_t);

    logic      clk;
    logic      rst;
    logic      act_valid;
    logic      act_ready;
    act_beat_t act_data;
    logic      wgt_valid;
    logic      wgt_ready;
    wgt_beat_t wgt_data;
    logic      res_valid;
    logic      res_ready;
    result_t   res_data;

    // Beats still to send, results still to arrive
    act_beat_t act_q [$];
    wgt_beat_t wgt_q [$];
    result_t   exp_q [$];

    int err_count;
    int tests_passed;
    int tests_failed;

    mvu_lut_top #(
        .SF                 (SF),
        .SIGNED_ACTIVATIONS (1'b1),
        .M_REG              (1),
        .OUT_DEPTH          (4)
    ) i_dut (.*);

    always #4 clk = ~clk;

    // Signed dot product over SF beats, wrapped to the accumulator width
    task automatic model_dot(
        input  act_beat_t av [SF],
        input  wgt_beat_t wv [SF],
        output result_t   r
    );
        int sum;
        for (int pe = 0; pe < int'(PE_COUNT); pe++) begin
            sum = 0;
            for (int b = 0; b < int'(SF); b++) begin
                for (int j = 0; j < int'(SIMD_COUNT); j++) begin
                    sum += int'($signed(av[b].elem[j]))
                         * int'($signed(wv[b].wgt[pe][j]));
                end
            end
            r.acc[pe] = ACC_WIDTH'(sum);
        end
    endtask

    task automatic random_dot();
        act_beat_t av [SF];
        wgt_beat_t wv [SF];
        result_t   r;
        for (int b = 0; b < int'(SF); b++) begin
            av[b] = ACT_BITS'($urandom);
            wv[b] = {$urandom, $urandom};
            act_q.push_back(av[b]);
            wgt_q.push_back(wv[b]);
        end
        model_dot(av, wv, r);
        exp_q.push_back(r);
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    // Every transferred result against the head of the expected queue
    always @(posedge clk) begin
        if (!rst && res_valid && res_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("A result arrived when none was expected: %h", res_data);
                err_count++;
            end
            if (exp_q.size() > 0) begin
                assert (res_data == exp_q[0]) else begin
                    $display("CHECK FAILED res_data expected %h actual %h",
                             exp_q[0], res_data);
                    err_count++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    `include "tb_mvu_lut_tasks.svh"

    initial begin
        void'($urandom(77));
        clk          = 1'b0;
        rst          = 1'b1;
        act_valid    = 1'b0;
        act_data     = '0;
        wgt_valid    = 1'b0;
        wgt_data     = '0;
        res_ready    = 1'b1;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;

        test_reset();
        test_known_values();
        test_back_to_back();
        test_misaligned();
        test_back_pressure();
        test_idle_gaps();

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_mvu_lut

`default_nettype wire
